// ==== obi_wb_bridge.f ====
rtl/bridge_pkg.sv
rtl/port_req_if.sv
rtl/obi_port_capture.sv
rtl/wb_timeout_counter.sv
rtl/wb_bus_fsm.sv
rtl/obi_wb_bridge.sv
sim/tb_wb_slave_model.sv
sim/tb_obi_wb_bridge.sv

// ==== rtl/bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // Instruction fetch carries only an address
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic              we;    // 1 = write
        logic [BE_W-1:0]   be;    // Byte enables
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } data_req_t;

    // Port currently owning the bus
    typedef enum logic {
        PORT_INSTR,
        PORT_DATA
    } port_sel_t;

endpackage

`default_nettype wire

// ==== rtl/obi_port_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module obi_port_capture
    import bridge_pkg::*;
#(
    parameter type req_t = instr_req_t
) (
    input  wire logic              sys_clk_i,
    input  wire logic              rst_n_i,

    input  wire logic              req_i,
    input  wire req_t              payload_i,
    output logic                   gnt_o,
    output logic                   rvalid_o,
    output logic [DATA_W-1:0]      rdata_o,
    output logic                   err_o,

    port_req_if.cap                bus
);

    logic              busy_q;     // Slot held, up to and including rvalid
    logic              pending_q;  // Waiting for the bus
    logic              rvalid_q;
    logic              err_q;
    logic [DATA_W-1:0] rdata_q;
    req_t              slot_q;
    logic              accept;

    assign gnt_o  = req_i && !busy_q;
    assign accept = req_i && gnt_o;

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            pending_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            rvalid_q <= bus.done;
            if (accept) begin
                busy_q    <= 1'b1;
                pending_q <= 1'b1;
            end else begin
                if (bus.done)
                    pending_q <= 1'b0;
                if (rvalid_q)
                    busy_q <= 1'b0;  // Free again after the response
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (accept)
            slot_q <= payload_i;
        if (bus.done) begin
            rdata_q <= bus.rdata;
            err_q   <= bus.err;
        end
    end

    assign bus.pending = pending_q;
    assign bus.payload = slot_q;

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign err_o    = err_q;

    // No new grant from acceptance through the matching rvalid
    a_no_gnt_while_held: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        accept |=> !gnt_o until_with rvalid_o);

    // Bus side only finishes a request this slot is actually waiting on
    a_done_only_pending: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        bus.done |-> pending_q);

endmodule

`default_nettype wire

// ==== rtl/obi_wb_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module obi_wb_bridge
    import bridge_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  wire logic              sys_clk_i,
    input  wire logic              rst_n_i,

    // Instruction port
    input  wire logic              instr_req_i,
    input  wire logic [ADDR_W-1:0] instr_addr_i,
    output logic                   instr_gnt_o,
    output logic                   instr_rvalid_o,
    output logic [DATA_W-1:0]      instr_rdata_o,
    output logic                   instr_err_o,

    // Data port
    input  wire logic              data_req_i,
    input  wire logic              data_we_i,
    input  wire logic [BE_W-1:0]   data_be_i,
    input  wire logic [ADDR_W-1:0] data_addr_i,
    input  wire logic [DATA_W-1:0] data_wdata_i,
    output logic                   data_gnt_o,
    output logic                   data_rvalid_o,
    output logic [DATA_W-1:0]      data_rdata_o,
    output logic                   data_err_o,

    // Wishbone master
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output logic [BE_W-1:0]        wb_wstrb_o,
    output logic [ADDR_W-1:0]      wb_addr_o,
    output logic [DATA_W-1:0]      wb_wdata_o,
    input  wire logic [DATA_W-1:0] wb_rdata_i,
    input  wire logic              wb_ack_i
);

    port_req_if #(.req_t(instr_req_t)) instr_bus_if ();
    port_req_if #(.req_t(data_req_t))  data_bus_if ();

    obi_port_capture #(
        .req_t (instr_req_t)
    ) u_instr_cap (
        .sys_clk_i (sys_clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (instr_req_i),
        .payload_i (instr_req_t'{addr: instr_addr_i}),
        .gnt_o     (instr_gnt_o),
        .rvalid_o  (instr_rvalid_o),
        .rdata_o   (instr_rdata_o),
        .err_o     (instr_err_o),
        .bus       (instr_bus_if.cap)
    );

    obi_port_capture #(
        .req_t (data_req_t)
    ) u_data_cap (
        .sys_clk_i (sys_clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (data_req_i),
        .payload_i (data_req_t'{we: data_we_i, be: data_be_i,
                                addr: data_addr_i, wdata: data_wdata_i}),
        .gnt_o     (data_gnt_o),
        .rvalid_o  (data_rvalid_o),
        .rdata_o   (data_rdata_o),
        .err_o     (data_err_o),
        .bus       (data_bus_if.cap)
    );

    wb_bus_fsm #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_bus_fsm (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .instr_bus  (instr_bus_if.fsm),
        .data_bus   (data_bus_if.fsm),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_wstrb_o (wb_wstrb_o),
        .wb_addr_o  (wb_addr_o),
        .wb_wdata_o (wb_wdata_o),
        .wb_rdata_i (wb_rdata_i),
        .wb_ack_i   (wb_ack_i)
    );

endmodule

`default_nettype wire

// ==== rtl/port_req_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface port_req_if
    import bridge_pkg::*;
#(
    parameter type req_t = instr_req_t
) ();

    logic              pending;  // One granted request waiting
    req_t              payload;
    logic              done;     // One-cycle end of request
    logic [DATA_W-1:0] rdata;
    logic              err;

    modport cap (
        output pending,
        output payload,
        input  done,
        input  rdata,
        input  err
    );

    modport fsm (
        input  pending,
        input  payload,
        output done,
        output rdata,
        output err
    );

endinterface

`default_nettype wire

// ==== rtl/wb_bus_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_bus_fsm
    import bridge_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  wire logic              sys_clk_i,
    input  wire logic              rst_n_i,

    port_req_if.fsm                instr_bus,
    port_req_if.fsm                data_bus,

    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output logic [BE_W-1:0]        wb_wstrb_o,
    output logic [ADDR_W-1:0]      wb_addr_o,
    output logic [DATA_W-1:0]      wb_wdata_o,
    input  wire logic [DATA_W-1:0] wb_rdata_i,
    input  wire logic              wb_ack_i
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        RESP
    } state_t;

    state_t            state_q;
    port_sel_t         sel_q;    // Port owning the current cycle
    port_sel_t         last_q;   // Last port served
    port_sel_t         pick;
    logic              any_pending;
    logic              tmo_expired;
    logic              we_q;
    logic [BE_W-1:0]   wstrb_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              err_q;

    assign any_pending = instr_bus.pending || data_bus.pending;

    // On a tie the port not served last wins
    always_comb begin
        if (instr_bus.pending && data_bus.pending)
            pick = (last_q == PORT_INSTR) ? PORT_DATA : PORT_INSTR;
        else if (data_bus.pending)
            pick = PORT_DATA;
        else
            pick = PORT_INSTR;
    end

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            sel_q   <= PORT_INSTR;
            last_q  <= PORT_DATA;  // Instruction port goes first
        end else begin
            case (state_q)
                IDLE: if (any_pending) begin
                    state_q <= ISSUE;
                    sel_q   <= pick;
                    last_q  <= pick;
                end
                ISSUE: if (wb_ack_i || tmo_expired)
                    state_q <= RESP;
                default: state_q <= IDLE;  // RESP lasts one cycle
            endcase
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (state_q == IDLE && any_pending) begin
            if (pick == PORT_INSTR) begin
                we_q    <= 1'b0;  // Fetch is always a full-word read
                wstrb_q <= '1;
                addr_q  <= instr_bus.payload.addr;
                wdata_q <= '0;
            end else begin
                we_q    <= data_bus.payload.we;
                wstrb_q <= data_bus.payload.be;
                addr_q  <= data_bus.payload.addr;
                wdata_q <= data_bus.payload.wdata;
            end
        end
        if (state_q == ISSUE && (wb_ack_i || tmo_expired)) begin
            rdata_q <= wb_ack_i ? wb_rdata_i : '0;  // Ack wins over a late expiry
            err_q   <= !wb_ack_i;
        end
    end

    wb_timeout_counter #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_timeout (
        .sys_clk_i (sys_clk_i),
        .rst_n_i   (rst_n_i),
        .run_i     (wb_stb_o),
        .expired_o (tmo_expired)
    );

    assign wb_cyc_o   = (state_q == ISSUE);
    assign wb_stb_o   = (state_q == ISSUE);
    assign wb_we_o    = we_q;
    assign wb_wstrb_o = wstrb_q;
    assign wb_addr_o  = addr_q;
    assign wb_wdata_o = wdata_q;

    assign instr_bus.done  = (state_q == RESP) && (sel_q == PORT_INSTR);
    assign instr_bus.rdata = rdata_q;
    assign instr_bus.err   = err_q;
    assign data_bus.done   = (state_q == RESP) && (sel_q == PORT_DATA);
    assign data_bus.rdata  = rdata_q;
    assign data_bus.err    = err_q;

    // Classic cycle holds cyc, stb and its fields until ack or expiry
    a_stb_hold: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i && !tmo_expired |=>
            wb_cyc_o && wb_stb_o && $stable(wb_addr_o) && $stable(wb_we_o)
            && $stable(wb_wstrb_o) && $stable(wb_wdata_o));

    a_instr_read_only: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        wb_cyc_o && sel_q == PORT_INSTR |-> !wb_we_o && wb_wstrb_o == '1);

endmodule

`default_nettype wire

// ==== rtl/wb_timeout_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_timeout_counter #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  wire logic sys_clk_i,
    input  wire logic rst_n_i,
    input  wire logic run_i,     // High while a bus cycle is open
    output logic      expired_o
);

    // One count beyond the limit so expiry drops as the cycle closes
    localparam int LIMIT = TIMEOUT_CYCLES + 1;
    localparam int CNT_W = $clog2(LIMIT + 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;
        end else if (cnt_q != CNT_W'(LIMIT)) begin
            cnt_q <= cnt_q + 1'b1;  // Saturate at LIMIT
        end
    end

    assign expired_o = (cnt_q == CNT_W'(TIMEOUT_CYCLES));

    // Master must drop the cycle once expiry is seen
    a_no_expiry_idle: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        !run_i |-> !expired_o);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_obi_wb_bridge \
    -f obi_wb_bridge.f \
    -o tb_obi_wb_bridge

./obj_dir/tb_obi_wb_bridge | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "Pass message found in sim.log"
    exit 0
fi

echo "Pass message missing from sim.log"
exit 1

// ==== sim/tb_obi_wb_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_obi_wb_bridge
    import bridge_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 16;
    localparam int NUM_REQS       = 400;
    localparam int MAX_CYCLES     = 2 * NUM_REQS * (TIMEOUT_CYCLES + 10);
    localparam int P_INSTR        = 0;
    localparam int P_DATA         = 1;

    logic              sys_clk_i;
    logic              rst_n_i;
    logic              instr_req_i;
    logic [ADDR_W-1:0] instr_addr_i;
    logic              instr_gnt_o;
    logic              instr_rvalid_o;
    logic [DATA_W-1:0] instr_rdata_o;
    logic              instr_err_o;
    logic              data_req_i;
    logic              data_we_i;
    logic [BE_W-1:0]   data_be_i;
    logic [ADDR_W-1:0] data_addr_i;
    logic [DATA_W-1:0] data_wdata_i;
    logic              data_gnt_o;
    logic              data_rvalid_o;
    logic [DATA_W-1:0] data_rdata_o;
    logic              data_err_o;
    logic              wb_cyc_o;
    logic              wb_stb_o;
    logic              wb_we_o;
    logic [BE_W-1:0]   wb_wstrb_o;
    logic [ADDR_W-1:0] wb_addr_o;
    logic [DATA_W-1:0] wb_wdata_o;
    logic [DATA_W-1:0] wb_rdata_i;
    logic              wb_ack_i;
    logic [2:0]        ack_delay;

    logic [DATA_W-1:0] model_mem [64];  // Reference copy of slave memory
    logic [31:0]       rng_state;
    int                errors;
    int                cycles;
    int                issued [2];
    int                resp_cnt [2];
    data_req_t         req_q [2];       // Accepted request per port
    logic [1:0]        held;            // Accepted, rvalid not seen yet
    logic [1:0]        waiting;         // Accepted, bus cycle not started
    logic [1:0]        snap;
    logic [1:0]        acc_seen;
    logic [1:0]        resp_due;
    logic [1:0]        exp_err;
    logic [1:0]        chk_rdata;
    logic [DATA_W-1:0] exp_rdata [2];
    logic              seen_req;
    logic              cyc_d;
    logic              acked;
    int                cur_port;
    int                last_port;

    obi_wb_bridge #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) dut_i (.*);

    tb_wb_slave_model u_slave (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cyc_o),
        .wb_stb_i   (wb_stb_o),
        .wb_we_i    (wb_we_o),
        .wb_wstrb_i (wb_wstrb_o),
        .wb_addr_i  (wb_addr_o),
        .wb_wdata_i (wb_wdata_o),
        .delay_i    (ack_delay),
        .wb_rdata_o (wb_rdata_i),
        .wb_ack_o   (wb_ack_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [BE_W-1:0]   be);
        for (int b = 0; b < BE_W; b++)
            if (be[b])
                old[8*b +: 8] = wdata[8*b +: 8];
        return old;
    endfunction

    // Bit 8 tags the port, bits 7:2 pick the word
    function automatic logic [ADDR_W-1:0] make_addr(input int port);
        logic [31:0] r;
        logic [3:0]  top;
        r   = next_rand();
        top = (r[31:28] == 4'hF) ? 4'hF : {1'b0, r[30:28]};  // 1 in 16 is dead
        return {top, r[27:9], port == P_DATA, r[5:0], 2'b00};
    endfunction

    function automatic logic want_request(input int port);
        logic [31:0] r;
        r = next_rand();
        if (issued[port] < NUM_REQS && r[1:0] != 2'b00) begin
            issued[port] = issued[port] + 1;
            seen_req     = 1'b1;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Check failed at %0t: %s", $time, msg);
    endtask

    task automatic watch_port(input int p, input string name, input logic req,
                              input logic gnt, input logic rvalid,
                              input logic [DATA_W-1:0] rdata, input logic err,
                              input data_req_t req_now);
        if (held[p]) begin
            assert (!gnt) else report_problem({name, " port granted while a request is held"});
        end else begin
            assert (gnt == req)
                else report_value({name, "_gnt_o"}, 32'(gnt), 32'(req));
        end
        if (req && gnt) begin
            req_q[p]    = req_now;
            held[p]     = 1'b1;
            waiting[p]  = 1'b1;
            acc_seen[p] = 1'b1;
        end
        if (rvalid) begin
            assert (resp_due[p]) else report_problem({name, " port rvalid with no response due"});
            assert (err == exp_err[p])
                else report_value({name, "_err_o"}, 32'(err), 32'(exp_err[p]));
            if (chk_rdata[p]) begin
                assert (rdata == exp_rdata[p])
                    else report_value({name, "_rdata_o"}, rdata, exp_rdata[p]);
            end
            resp_due[p] = 1'b0;
            held[p]     = 1'b0;
            resp_cnt[p] = resp_cnt[p] + 1;
        end
    endtask

    task automatic watch_bus();
        int        p;
        int        exp_p;
        int        idx;
        logic      dead;
        data_req_t rq;
        if (wb_cyc_o && !cyc_d) begin
            p = wb_addr_o[8] ? P_DATA : P_INSTR;
            // Tie goes to the port not served last
            if (snap[P_INSTR] && snap[P_DATA])
                exp_p = (last_port == P_INSTR) ? P_DATA : P_INSTR;
            else
                exp_p = snap[P_DATA] ? P_DATA : P_INSTR;
            assert (snap != 2'b00) else report_problem("Bus cycle began with no request waiting");
            assert (p == exp_p)
                else report_problem($sformatf("Arbiter served port %0d, expected %0d", p, exp_p));
            waiting[p] = 1'b0;
            cur_port   = p;
            last_port  = p;
            acked      = 1'b0;
        end
        rq = req_q[cur_port];
        if (wb_cyc_o) begin
            assert (wb_stb_o) else report_value("wb_stb_o", 32'(wb_stb_o), 32'h1);
            assert (wb_addr_o == rq.addr) else report_value("wb_addr_o", wb_addr_o, rq.addr);
            assert (wb_we_o == rq.we) else report_value("wb_we_o", 32'(wb_we_o), 32'(rq.we));
            assert (wb_wstrb_o == rq.be)
                else report_value("wb_wstrb_o", 32'(wb_wstrb_o), 32'(rq.be));
            if (rq.we) begin
                assert (wb_wdata_o == rq.wdata)
                    else report_value("wb_wdata_o", wb_wdata_o, rq.wdata);
            end
            if (wb_ack_i)
                acked = 1'b1;
        end
        if (!wb_cyc_o && cyc_d) begin  // Closed by ack or watchdog
            dead = (rq.addr[31:28] == 4'hF);
            idx  = int'(rq.addr[7:2]);
            assert (acked != dead)
                else report_problem(dead ? "Dead region address was acked"
                                         : "Bus cycle closed without an ack");
            exp_err[cur_port]   = dead;
            exp_rdata[cur_port] = dead ? '0 : model_mem[idx];
            chk_rdata[cur_port] = dead || !rq.we;
            if (!dead && rq.we)
                model_mem[idx] = merge_bytes(model_mem[idx], rq.wdata, rq.be);
            resp_due[cur_port] = 1'b1;
        end
        snap  = waiting;  // What the FSM sees at its next IDLE decision
        cyc_d = wb_cyc_o;
    endtask

    initial begin
        sys_clk_i = 1'b0;
        forever #4 sys_clk_i = ~sys_clk_i;
    end

    // Outputs are sampled mid-cycle, away from both clock edges
    always @(negedge sys_clk_i) begin : monitor
        data_req_t fetch;
        data_req_t dreq;
        fetch = '{we: 1'b0, be: '1, addr: instr_addr_i, wdata: '0};
        dreq  = '{we: data_we_i, be: data_be_i, addr: data_addr_i, wdata: data_wdata_i};
        if (!seen_req) begin
            assert (!wb_cyc_o && !wb_stb_o && !instr_rvalid_o && !data_rvalid_o)
                else report_problem("Bus or rvalid active before the first request");
        end
        if (rst_n_i) begin
            watch_bus();
            watch_port(P_INSTR, "instr", instr_req_i, instr_gnt_o, instr_rvalid_o,
                       instr_rdata_o, instr_err_o, fetch);
            watch_port(P_DATA, "data", data_req_i, data_gnt_o, data_rvalid_o,
                       data_rdata_o, data_err_o, dreq);
        end
    end

    initial begin
        rng_state    = 32'h9fb7_8c79;
        errors       = 0;
        cycles       = 0;
        issued       = '{0, 0};
        resp_cnt     = '{0, 0};
        held         = '0;
        waiting      = '0;
        snap         = '0;
        acc_seen     = '0;
        resp_due     = '0;
        exp_err      = '0;
        chk_rdata    = '0;
        seen_req     = 1'b0;
        cyc_d        = 1'b0;
        acked        = 1'b0;
        cur_port     = P_INSTR;
        last_port    = P_DATA;  // Instruction port wins the first tie
        rst_n_i      = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        ack_delay    = '0;

        repeat (3) @(posedge sys_clk_i);
        for (int i = 0; i < 64; i++)
            model_mem[i] = u_slave.mem[i];
        #1 rst_n_i = 1'b1;

        while ((resp_cnt[P_INSTR] < NUM_REQS || resp_cnt[P_DATA] < NUM_REQS)
               && cycles < MAX_CYCLES) begin
            @(posedge sys_clk_i);
            #1;
            cycles++;
            ack_delay = 3'(next_rand() % 32'd6);
            // OBI requests hold until granted
            if (!instr_req_i || acc_seen[P_INSTR]) begin
                acc_seen[P_INSTR] = 1'b0;
                instr_req_i       = want_request(P_INSTR);
                instr_addr_i      = make_addr(P_INSTR);
            end
            if (!data_req_i || acc_seen[P_DATA]) begin
                acc_seen[P_DATA] = 1'b0;
                data_req_i       = want_request(P_DATA);
                data_addr_i      = make_addr(P_DATA);
                data_wdata_i     = next_rand();
                data_be_i        = 4'(next_rand() >> 4);
                data_we_i        = rng_state[0];  // Independent of the word index
            end
        end

        repeat (5) @(posedge sys_clk_i);  // Room for a stray rvalid
        assert (resp_cnt[P_INSTR] == NUM_REQS && resp_cnt[P_DATA] == NUM_REQS)
            else report_problem($sformatf("Timeout after %0d cycles", cycles));
        assert (held == 2'b00 && resp_due == 2'b00)
            else report_problem("Requests were left without a response");

        $display("Errors: %0d, instr responses: %0d, data responses: %0d, cycles: %0d",
                 errors, resp_cnt[P_INSTR], resp_cnt[P_DATA], cycles);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_wb_slave_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_wb_slave_model
    import bridge_pkg::*;
(
    input  wire logic              sys_clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    input  wire logic              wb_we_i,
    input  wire logic [BE_W-1:0]   wb_wstrb_i,
    input  wire logic [ADDR_W-1:0] wb_addr_i,
    input  wire logic [DATA_W-1:0] wb_wdata_i,
    input  wire logic [2:0]        delay_i,     // Wait states before ack
    output logic [DATA_W-1:0]      wb_rdata_o,
    output logic                   wb_ack_o
);

    logic [DATA_W-1:0] mem [64];
    logic [2:0]        wait_cnt;
    logic [5:0]        idx;
    logic              dead;

    assign idx  = wb_addr_i[7:2];
    assign dead = (wb_addr_i[31:28] == 4'hF);  // Dead region never answers

    // Every word differs, pattern spans all index bits
    initial begin
        for (int i = 0; i < 64; i++)
            mem[i] = 32'hc3a5_0000 ^ (32'(i) << 26) ^ (32'(i) * 32'h0000_0409);
    end

    always @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            wait_cnt <= '0;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;  // Single-cycle ack
            wait_cnt <= '0;
        end else if (wb_cyc_i && wb_stb_i && !dead) begin
            if (wait_cnt >= delay_i) begin
                wb_ack_o   <= 1'b1;
                wb_rdata_o <= mem[idx];
                for (int b = 0; b < BE_W; b++)
                    if (wb_we_i && wb_wstrb_i[b])
                        mem[idx][8*b +: 8] <= wb_wdata_i[8*b +: 8];
            end else begin
                wait_cnt <= wait_cnt + 3'd1;
            end
        end else begin
            wait_cnt <= '0;
        end
    end

endmodule

`default_nettype wire
